/* verif/vga_game_cases.txt */
// columns: frame x y colour, frame counted from reset, x and y are raster counts
// colour is the RGB332 byte in hex, 1c cactus, ec bird, 00 black
0 33 22 1c
0 31 19 1c
0 30 22 00
0 36 22 00
0 33 18 00
0 33 28 00
0 25 17 ec
0 21 15 ec
0 20 17 00
0 25 14 00
0 25 20 00
0 5 5 00
0 20 31 00
1 28 22 1c
1 18 17 ec
2 25 25 1c
2 17 16 ec
3 20 27 1c
3 18 27 00
4 15 19 1c
4 13 19 ec
4 14 19 00
5 13 22 1c
5 5 17 ec
5 0 17 00
6 9 22 1c
6 5 17 00
7 5 22 1c
7 38 17 ec
8 5 22 00
8 39 22 00
8 35 17 ec
8 39 19 ec
9 37 19 1c
9 37 18 ec
9 37 20 1c
9 39 22 1c
9 41 19 00
9 33 17 ec

/* vlog.f */
rtl/vga_game_pkg.sv
rtl/scan_if.sv
rtl/vga_timing.sv
rtl/obstacle.sv
rtl/pixel_color.sv
rtl/vga_game_top.sv
verif/vga_game_tb.sv

/* Bender.yml */
package:
  name: vga_game

sources:
  - files:
      - rtl/vga_game_pkg.sv
      - rtl/scan_if.sv
      - rtl/vga_timing.sv
      - rtl/obstacle.sv
      - rtl/pixel_color.sv
      - rtl/vga_game_top.sv
  - target: simulation
    files:
      - verif/vga_game_tb.sv

# simulation top: vga_game_tb
# synthesis top: vga_game_top

/* verif/vga_game_tb.sv */
////////////////////////////////////////
// testbench for the VGA obstacle renderer on a small raster
// records the pins every CLK, anchors on vsync, checks against the cases file
////////////////////////////////////////

`timescale 1ns/1ps

module vga_game_tb;

    localparam int PIX_DIV   = 4;
    localparam int H_ACTIVE  = 40;
    localparam int H_FP      = 4;
    localparam int H_SYNC    = 6;
    localparam int H_TOTAL   = 56;
    localparam int V_ACTIVE  = 30;
    localparam int V_FP      = 2;
    localparam int V_SYNC    = 3;
    localparam int V_TOTAL   = 38;
    localparam int FRAME_PIX = H_TOTAL * V_TOTAL;
    localparam int FIRST_VS  = (V_ACTIVE + V_FP) * H_TOTAL;  // pixel index where vs drops
    localparam int WAIT_MAX  = 3 * FRAME_PIX * PIX_DIV;      // cycles for the vsync search

    logic       CLK;
    logic       i_rst_n;
    logic       o_hs;
    logic       o_vs;
    logic [2:0] o_r;
    logic [2:0] o_g;
    logic [1:0] o_b;

    logic       recording;
    logic [9:0] hist [$];                  // {hs, vs, r, g, b} sampled once per CLK
    realtime    hist_t [$];                // sample time of each entry

    int         case_f [$];
    int         case_x [$];
    int         case_y [$];
    logic [7:0] case_c [$];
    int         last_frame;

    int         checks;
    int         sync_errs;
    int         color_errs;
    int         other_errs;
    int         anchor;                    // history index of the first vs low sample
    bit         ok;

    vga_game_top #(
        .PIX_DIV(PIX_DIV), .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC),
        .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC),
        .V_TOTAL(V_TOTAL),
        .CACTUS_IX(30), .CACTUS_IY(18), .CACTUS_W(6), .CACTUS_H(10), .CACTUS_SPEED(4),
        .BIRD_IX(20), .BIRD_IY(14), .BIRD_W(10), .BIRD_H(6), .BIRD_SPEED(4)
    ) UUT (
        .CLK(CLK), .i_rst_n(i_rst_n), .o_hs(o_hs), .o_vs(o_vs),
        .o_r(o_r), .o_g(o_g), .o_b(o_b)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;             // 8 ns period
    end

    // pins settle after posedge so negedge sees a stable value
    always @(negedge CLK) begin
        if (recording) begin
            hist.push_back({o_hs, o_vs, o_r, o_g, o_b});
            hist_t.push_back($realtime);
        end
    end

    // history index of raster pixel (x, y) in frame f counted from reset
    function automatic int sample_of(int f, int x, int y);
        return anchor + PIX_DIV * ((f * V_TOTAL + y) * H_TOTAL + x - FIRST_VS);
    endfunction

    task automatic load_cases();
        int         fd;
        int         n;
        int         f;
        int         x;
        int         y;
        logic [7:0] c;
        string      line;
        fd = $fopen("verif/vga_game_cases.txt", "r");
        last_frame = 0;
        if (fd == 0) begin
            $display("could not open verif/vga_game_cases.txt");
            other_errs++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%d %d %d %h", f, x, y, c);  // comment lines give 0
                if (n == 4) begin
                    if (c != 8'h00 && c != vga_game_pkg::CACTUS_COLOR &&
                        c != vga_game_pkg::BIRD_COLOR) begin
                        $display("case line for frame %0d x %0d y %0d has unknown colour %h",
                                 f, x, y, c);
                        other_errs++;
                    end
                    case_f.push_back(f);
                    case_x.push_back(x);
                    case_y.push_back(y);
                    case_c.push_back(c);
                    if (f > last_frame)
                        last_frame = f;
                end
            end
            $fclose(fd);
        end
        if (case_f.size() == 0) begin
            $display("the cases file holds no usable lines");
            other_errs++;
        end
    endtask

    // sync idle high and colour black at this moment
    task automatic check_idle();
        checks++;
        assert (o_hs === 1'b1) else begin
            sync_errs++;
            $display("Error at %0.1f ns: o_hs expected 1, got %b", $realtime, o_hs);
        end
        assert (o_vs === 1'b1) else begin
            sync_errs++;
            $display("Error at %0.1f ns: o_vs expected 1, got %b", $realtime, o_vs);
        end
        assert ({o_r, o_g, o_b} === 8'h00) else begin
            color_errs++;
            $display("Error at %0.1f ns: {o_r,o_g,o_b} expected 00, got %h", $realtime,
                     {o_r, o_g, o_b});
        end
    endtask

    // hold reset over two edges mid-frame, check the pins, then restart recording
    task automatic pulse_reset();
        @(posedge CLK);
        i_rst_n <= 1'b0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        check_idle();
        @(posedge CLK);
        hist.delete();
        hist_t.delete();
        i_rst_n <= 1'b1;
    endtask

    task automatic find_vs_fall(output int idx, output bit found);
        int i;
        int cycles;
        i      = 1;
        cycles = 0;
        found  = 1'b0;
        idx    = 0;
        while (!found && cycles < WAIT_MAX) begin
            @(posedge CLK);
            cycles++;
            while (!found && i < hist.size()) begin
                if (hist[i-1][8] && !hist[i][8]) begin  // high then low
                    found = 1'b1;
                    idx   = i;
                end
                i++;
            end
        end
        if (!found) begin
            $display("timeout: o_vs never fell within %0d cycles", WAIT_MAX);
            other_errs++;
        end
    endtask

    task automatic wait_history(input int need, output bit done);
        int cycles;
        int limit;
        cycles = 0;
        limit  = need - hist.size() + 64;  // one entry per CLK plus slack
        while (hist.size() <= need && cycles < limit) begin
            @(posedge CLK);
            cycles++;
        end
        done = (hist.size() > need);
        if (!done) begin
            $display("timeout: pin history stopped short of sample %0d", need);
            other_errs++;
        end
    endtask

    // every CLK of the next npix pixels from the anchor on
    task automatic check_sync(input int npix);
        int         p;
        int         s;
        int         lin;
        int         x;
        int         y;
        int         idx;
        logic       exp_hs;
        logic       exp_vs;
        logic [9:0] smp;
        for (p = 0; p < npix; p++) begin
            lin    = FIRST_VS + p;
            x      = lin % H_TOTAL;
            y      = (lin / H_TOTAL) % V_TOTAL;
            exp_hs = !(x >= H_ACTIVE + H_FP && x < H_ACTIVE + H_FP + H_SYNC);
            exp_vs = !(y >= V_ACTIVE + V_FP && y < V_ACTIVE + V_FP + V_SYNC);
            for (s = 0; s < PIX_DIV; s++) begin
                idx = anchor + p * PIX_DIV + s;
                smp = hist[idx];
                checks++;
                assert (smp[9] == exp_hs) else begin
                    sync_errs++;
                    $display("Error at %0.1f ns: o_hs expected %b, got %b",
                             hist_t[idx], exp_hs, smp[9]);
                end
                assert (smp[8] == exp_vs) else begin
                    sync_errs++;
                    $display("Error at %0.1f ns: o_vs expected %b, got %b",
                             hist_t[idx], exp_vs, smp[8]);
                end
            end
        end
    endtask

    task automatic check_cases(input int max_frame);
        int         k;
        int         s;
        int         first;
        logic [9:0] smp;
        string      where;
        for (k = 0; k < case_f.size(); k++) begin
            if (case_f[k] <= max_frame) begin
                first = sample_of(case_f[k], case_x[k], case_y[k]);
                where = $sformatf("frame %0d x %0d y %0d", case_f[k], case_x[k], case_y[k]);
                if (first < 0 || first + PIX_DIV > hist.size()) begin
                    $display("case %s lies outside the recorded pins", where);
                    other_errs++;
                end else begin
                    for (s = 0; s < PIX_DIV; s++) begin  // colour holds the whole pixel
                        smp = hist[first + s];
                        checks++;
                        assert (smp[7:0] == case_c[k]) else begin
                            color_errs++;
                            $display("Error at %0.1f ns: {o_r,o_g,o_b} at %s expected %h, got %h",
                                     hist_t[first + s], where, case_c[k], smp[7:0]);
                        end
                    end
                end
            end
        end
    endtask

    initial begin
        i_rst_n    = 1'b0;
        recording  = 1'b0;
        checks     = 0;
        sync_errs  = 0;
        color_errs = 0;
        other_errs = 0;
        anchor     = 0;
        ok         = 1'b0;
        load_cases();

        repeat (2) @(posedge CLK);
        i_rst_n  <= 1'b1;
        recording = 1'b1;
        @(negedge CLK);
        check_idle();

        find_vs_fall(anchor, ok);
        if (ok)
            wait_history(anchor + 2 * FRAME_PIX * PIX_DIV, ok);  // two vs periods
        if (ok) begin
            check_sync(2 * FRAME_PIX);
            wait_history(sample_of(last_frame + 1, 0, 0), ok);
        end
        if (ok) begin
            check_cases(last_frame);
            wait_history(sample_of(10, 46, 33), ok);             // inside both sync pulses
        end

        // reset in the middle of a frame brings frame 0 back
        if (ok) begin
            pulse_reset();
            find_vs_fall(anchor, ok);
        end
        if (ok)
            wait_history(anchor + FRAME_PIX * PIX_DIV, ok);
        if (ok) begin
            check_sync(FRAME_PIX);
            check_cases(0);
            wait_history(sample_of(2, 25, 25), ok);              // cactus covers this pixel
        end
        if (ok)
            pulse_reset();                                       // now over a coloured pixel

        $display("checks %0d, sync errors %0d, colour errors %0d, other errors %0d",
                 checks, sync_errs, color_errs, other_errs);
        if (sync_errs + color_errs + other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* rtl/vga_game_top.sv */
////////////////////////////////////////
// VGA obstacle renderer top, RGB332 out
// all raster and sprite geometry set from here
////////////////////////////////////////

`timescale 1ns/1ps

module vga_game_top #(
    parameter int PIX_DIV      = 4,        // 100 MHz CLK gives 25 MHz pixels
    parameter int H_ACTIVE     = 640,
    parameter int H_FP         = 16,
    parameter int H_SYNC       = 96,
    parameter int H_TOTAL      = 800,
    parameter int V_ACTIVE     = 480,
    parameter int V_FP         = 10,
    parameter int V_SYNC       = 2,
    parameter int V_TOTAL      = 525,
    parameter int CACTUS_IX    = 600,      // ground obstacle
    parameter int CACTUS_IY    = 400,
    parameter int CACTUS_W     = 20,
    parameter int CACTUS_H     = 40,
    parameter int CACTUS_SPEED = 4,
    parameter int BIRD_IX      = 400,      // flying obstacle, above the cactus
    parameter int BIRD_IY      = 340,
    parameter int BIRD_W       = 40,
    parameter int BIRD_H       = 20,
    parameter int BIRD_SPEED   = 4
) (
    input  logic       CLK,
    input  logic       i_rst_n,
    output logic       o_hs,
    output logic       o_vs,
    output logic [2:0] o_r,
    output logic [2:0] o_g,
    output logic [1:0] o_b
);

    scan_if scan ();

    vga_game_pkg::box_t   boxes [vga_game_pkg::NUM_OBSTACLES];
    vga_game_pkg::pixel_t pixel;

    vga_timing #(
        .PIX_DIV (PIX_DIV),  .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC),
        .H_TOTAL (H_TOTAL),  .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC),
        .V_TOTAL (V_TOTAL)
    ) u_timing (
        .CLK    (CLK),
        .i_rst_n(i_rst_n),
        .o_scan (scan.timing)
    );

    // index 0 has colour priority
    obstacle #(
        .IX(CACTUS_IX), .IY(CACTUS_IY), .WIDTH(CACTUS_W), .HEIGHT(CACTUS_H),
        .SPEED(CACTUS_SPEED), .H_ACTIVE(H_ACTIVE)
    ) u_cactus (
        .CLK(CLK), .i_rst_n(i_rst_n), .i_scan(scan.sink), .o_box(boxes[0])
    );

    obstacle #(
        .IX(BIRD_IX), .IY(BIRD_IY), .WIDTH(BIRD_W), .HEIGHT(BIRD_H),
        .SPEED(BIRD_SPEED), .H_ACTIVE(H_ACTIVE)
    ) u_bird (
        .CLK(CLK), .i_rst_n(i_rst_n), .i_scan(scan.sink), .o_box(boxes[1])
    );

    pixel_color #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC)
    ) u_color (
        .CLK    (CLK),
        .i_rst_n(i_rst_n),
        .i_scan (scan.sink),
        .i_boxes(boxes),
        .o_hs   (o_hs),
        .o_vs   (o_vs),
        .o_pixel(pixel)
    );

    assign o_r = pixel.rgb.r;              // channel split via union view
    assign o_g = pixel.rgb.g;
    assign o_b = pixel.rgb.b;

endmodule

/* rtl/pixel_color.sv */
////////////////////////////////////////
// hit test against all boxes, priority colour, sync decode
// outputs registered on the pixel strobe
////////////////////////////////////////

`timescale 1ns/1ps

module pixel_color #(
    parameter int H_ACTIVE = 640,
    parameter int H_FP     = 16,
    parameter int H_SYNC   = 96,
    parameter int V_ACTIVE = 480,
    parameter int V_FP     = 10,
    parameter int V_SYNC   = 2
) (
    input  logic                 CLK,
    input  logic                 i_rst_n,
    scan_if.sink                 i_scan,
    input  vga_game_pkg::box_t   i_boxes [vga_game_pkg::NUM_OBSTACLES],
    output logic                 o_hs,
    output logic                 o_vs,
    output vga_game_pkg::pixel_t o_pixel
);

    localparam int CW = vga_game_pkg::COORD_W;
    localparam int NO = vga_game_pkg::NUM_OBSTACLES;

    localparam logic [CW-1:0] HS_START = CW'(H_ACTIVE + H_FP);
    localparam logic [CW-1:0] HS_END   = CW'(H_ACTIVE + H_FP + H_SYNC);
    localparam logic [CW-1:0] VS_START = CW'(V_ACTIVE + V_FP);
    localparam logic [CW-1:0] VS_END   = CW'(V_ACTIVE + V_FP + V_SYNC);

    // colour per obstacle index
    localparam logic [7:0] OBJ_COLOR [NO] = '{vga_game_pkg::CACTUS_COLOR,
                                              vga_game_pkg::BIRD_COLOR};

    logic [NO-1:0]        hit;
    logic                 hs_n;            // low during sync pulse
    logic                 vs_n;
    vga_game_pkg::pixel_t next_pix;

    // strictly inside, edges stay black
    for (genvar i = 0; i < NO; i++) begin : g_hit
        assign hit[i] = (i_scan.x > i_boxes[i].x1) && (i_scan.x < i_boxes[i].x2) &&
                        (i_scan.y > i_boxes[i].y1) && (i_scan.y < i_boxes[i].y2);
    end

    // walk from highest index down so index 0 wins last
    always_comb begin
        next_pix.raw = 8'h00;
        for (int i = NO - 1; i >= 0; i--) begin
            if (hit[i])
                next_pix.raw = OBJ_COLOR[i];
        end
        if (!i_scan.active)
            next_pix.raw = 8'h00;          // blanking always black
    end

    assign hs_n = !((i_scan.x >= HS_START) && (i_scan.x < HS_END));
    assign vs_n = !((i_scan.y >= VS_START) && (i_scan.y < VS_END));

    // all three pins move together, one CLK after the strobe
    always_ff @(posedge CLK) begin
        if (!i_rst_n) begin
            o_hs        <= 1'b1;           // sync idle high
            o_vs        <= 1'b1;
            o_pixel.raw <= 8'h00;
        end else if (i_scan.pix_stb) begin
            o_hs        <= hs_n;
            o_vs        <= vs_n;
            o_pixel     <= next_pix;
        end
    end

endmodule

/* rtl/obstacle.sv */
////////////////////////////////////////
// one rectangle scrolling left by SPEED per frame
// wraps back to the right edge once it runs off the left
////////////////////////////////////////

`timescale 1ns/1ps

module obstacle #(
    parameter int IX       = 600,          // start x, left edge
    parameter int IY       = 400,          // fixed top edge
    parameter int WIDTH    = 20,
    parameter int HEIGHT   = 40,
    parameter int SPEED    = 4,            // pixels per frame
    parameter int H_ACTIVE = 640           // wrap target
) (
    input  logic                 CLK,
    input  logic                 i_rst_n,
    scan_if.sink                 i_scan,
    output vga_game_pkg::box_t   o_box
);

    localparam int CW = vga_game_pkg::COORD_W;

    localparam logic [CW-1:0] START_X = CW'(IX);
    localparam logic [CW-1:0] STEP    = CW'(SPEED);
    localparam logic [CW-1:0] WRAP_X  = CW'(H_ACTIVE);
    localparam logic [CW-1:0] BOX_W   = CW'(WIDTH);
    localparam logic [CW-1:0] TOP_Y   = CW'(IY);
    localparam logic [CW-1:0] BOT_Y   = CW'(IY + HEIGHT);

    logic [CW-1:0] x1;                     // only moving edge

    // step on the animate strobe, box visible from the next cycle
    always_ff @(posedge CLK) begin
        if (!i_rst_n) begin
            x1 <= START_X;
        end else if (i_scan.animate) begin
            if (x1 < STEP)
                x1 <= WRAP_X;              // off the left, restart at right
            else
                x1 <= x1 - STEP;
        end
    end

    assign o_box.x1 = x1;
    assign o_box.x2 = x1 + BOX_W;          // may lie past H_ACTIVE after wrap
    assign o_box.y1 = TOP_Y;
    assign o_box.y2 = BOT_Y;

endmodule

/* rtl/vga_timing.sv */
////////////////////////////////////////
// raster generator: pixel strobe plus line and frame counters
// sync is decoded downstream from the counts
////////////////////////////////////////

`timescale 1ns/1ps

module vga_timing #(
    parameter int PIX_DIV  = 4,            // CLK cycles per pixel
    parameter int H_ACTIVE = 640,
    parameter int H_FP     = 16,
    parameter int H_SYNC   = 96,
    parameter int H_TOTAL  = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_FP     = 10,
    parameter int V_SYNC   = 2,
    parameter int V_TOTAL  = 525
) (
    input  logic   CLK,
    input  logic   i_rst_n,
    scan_if.timing o_scan
);

    localparam int CW    = vga_game_pkg::COORD_W;
    localparam int DIV_W = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;

    // back porch is whatever is left of the line after active, fp and sync
    localparam int H_BP = H_TOTAL - H_ACTIVE - H_FP - H_SYNC;
    localparam int V_BP = V_TOTAL - V_ACTIVE - V_FP - V_SYNC;

    localparam logic [CW-1:0] H_LAST = CW'(H_ACTIVE + H_FP + H_SYNC + H_BP - 1);
    localparam logic [CW-1:0] V_LAST = CW'(V_ACTIVE + V_FP + V_SYNC + V_BP - 1);

    logic [DIV_W-1:0] div_cnt;             // cycles since last strobe
    logic             pix_stb;
    logic [CW-1:0]    h_cnt;
    logic [CW-1:0]    v_cnt;
    logic             line_end;

    // strobe lands PIX_DIV cycles after reset release, then every PIX_DIV
    always_ff @(posedge CLK) begin
        if (!i_rst_n) begin
            div_cnt <= '0;
            pix_stb <= 1'b0;
        end else if (div_cnt == DIV_W'(PIX_DIV - 1)) begin
            div_cnt <= '0;
            pix_stb <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            pix_stb <= 1'b0;
        end
    end

    assign line_end = (h_cnt == H_LAST);

    // counters hold the position of the pixel being strobed
    always_ff @(posedge CLK) begin
        if (!i_rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (pix_stb) begin
            if (line_end) begin
                h_cnt <= '0;                    // wrap to next line
                if (v_cnt == V_LAST)
                    v_cnt <= '0;                // new frame
                else
                    v_cnt <= v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    assign o_scan.pix_stb = pix_stb;
    assign o_scan.x       = h_cnt;
    assign o_scan.y       = v_cnt;
    assign o_scan.active  = (h_cnt < CW'(H_ACTIVE)) && (v_cnt < CW'(V_ACTIVE));

    // first blanking line, first pixel: safe point to move sprites
    assign o_scan.animate = pix_stb && (v_cnt == CW'(V_ACTIVE)) && (h_cnt == '0);

endmodule

/* rtl/scan_if.sv */
////////////////////////////////////////
// scan position and strobes from the timing generator
////////////////////////////////////////

`timescale 1ns/1ps

interface scan_if;

    logic                               pix_stb;  // one CLK wide, every PIX_DIV cycles
    logic [vga_game_pkg::COORD_W-1:0]   x;        // horizontal count, 0..H_TOTAL-1
    logic [vga_game_pkg::COORD_W-1:0]   y;        // vertical count, 0..V_TOTAL-1
    logic                               active;   // pixel inside visible area
    logic                               animate;  // once per frame, start of blanking

    // driven by vga_timing only
    modport timing (
        output pix_stb,
        output x,
        output y,
        output active,
        output animate
    );

    // obstacles and compositor
    modport sink (
        input pix_stb,
        input x,
        input y,
        input active,
        input animate
    );

endinterface

/* rtl/vga_game_pkg.sv */
////////////////////////////////////////
// shared types and constants for the VGA obstacle renderer
// referenced by scoped name from every block and the testbench
////////////////////////////////////////

package vga_game_pkg;

    // every screen coordinate and box edge uses this width
    localparam int COORD_W = 12;           // 0..4095, plenty for 800x525

    localparam int NUM_OBSTACLES = 2;      // index 0 cactus, index 1 bird

    // exclusive bounding box of one obstacle
    // a pixel is inside only when strictly between both edge pairs
    typedef struct packed {
        logic [COORD_W-1:0] x1;            // left edge
        logic [COORD_W-1:0] x2;            // right edge
        logic [COORD_W-1:0] y1;            // top edge
        logic [COORD_W-1:0] y2;            // bottom edge
    } box_t;                               // 48 bits

    // RGB332 split, red in the top bits
    typedef struct packed {
        logic [2:0] r;
        logic [2:0] g;
        logic [1:0] b;
    } rgb_t;

    // one colour word, seen as a byte or as channels
    typedef union packed {
        logic [7:0] raw;                   // written by the compositor
        rgb_t       rgb;                   // read at the pins
    } pixel_t;

    // obstacle colours in RGB332
    localparam logic [7:0] CACTUS_COLOR = 8'b000_111_00;  // full green
    localparam logic [7:0] BIRD_COLOR   = 8'b111_011_00;  // orange-ish

    // Black is all zeros, used for blanking and background.

endpackage
